// File: Makefile
VERILATOR = verilator
FLAGS     = --timing
TOP       = tb_core
FILELIST  = project.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run may stop on $fatal, so the log decides the result.
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: project.f
source/core_pkg.sv
source/core_ctrl.sv
source/core_decode.sv
source/core_regfile.sv
source/core_alu.sv
source/core_pc.sv
source/core_mem_port.sv
source/core_top.sv
testbench/tb_core.sv

// File: source/core_alu.sv
module core_alu (
    input  core_pkg::op_t op,
    input  logic [31:0]   a,
    input  logic [31:0]   b,
    input  logic [31:0]   imm,
    input  logic [31:0]   pc,
    output logic [31:0]   result,
    output logic          take_branch
);

    always_comb begin
        case (op)
            core_pkg::op_add:   result = a + b;
            core_pkg::op_sub:   result = a - b;
            core_pkg::op_and:   result = a & b;
            core_pkg::op_or:    result = a | b;
            core_pkg::op_xor:   result = a ^ b;
            core_pkg::op_slt:   result = {31'b0, $signed(a) < $signed(b)};
            core_pkg::op_sltu:  result = {31'b0, a < b};
            core_pkg::op_sll:   result = a << b[4:0];
            core_pkg::op_srl:   result = a >> b[4:0];
            core_pkg::op_sra:   result = $signed(a) >>> b[4:0];
            core_pkg::op_andi:  result = a & imm;
            core_pkg::op_ori:   result = a | imm;
            core_pkg::op_xori:  result = a ^ imm;
            core_pkg::op_slti:  result = {31'b0, $signed(a) < $signed(imm)};
            core_pkg::op_sltiu: result = {31'b0, a < imm};
            core_pkg::op_slli:  result = a << imm[4:0];
            core_pkg::op_srli:  result = a >> imm[4:0];
            core_pkg::op_srai:  result = $signed(a) >>> imm[4:0];
            core_pkg::op_lui:   result = imm;
            core_pkg::op_auipc: result = pc + imm;
            // addi and the load/store effective address.
            default:            result = a + imm;
        endcase
    end

    always_comb begin
        case (op)
            core_pkg::op_beq:  take_branch = (a == b);
            core_pkg::op_bne:  take_branch = (a != b);
            core_pkg::op_blt:  take_branch = $signed(a) < $signed(b);
            core_pkg::op_bge:  take_branch = $signed(a) >= $signed(b);
            core_pkg::op_bltu: take_branch = a < b;
            core_pkg::op_bgeu: take_branch = a >= b;
            default:           take_branch = 1'b0;
        endcase
    end

endmodule

// File: source/core_ctrl.sv
module core_ctrl (
    input  logic          clock,
    input  logic          rst,
    input  core_pkg::op_t op,
    input  logic          mem_done,
    output logic          fetch_req,
    output logic          data_req,
    output logic          inst_load,
    output logic          reg_wen,
    output logic          pc_step,
    output logic          halted
);

    core_pkg::state_t state;
    core_pkg::state_t state_next;
    logic             needs_mem;
    logic             stops;
    logic             writes_rd;

    assign needs_mem = core_pkg::op_is_load(op) || core_pkg::op_is_store(op);
    assign stops     = (op == core_pkg::op_ebreak) || (op == core_pkg::op_illegal);

    // stores, branches and halting ops have no destination.
    always_comb begin
        case (op)
            core_pkg::op_sb, core_pkg::op_sh, core_pkg::op_sw,
            core_pkg::op_beq, core_pkg::op_bne, core_pkg::op_blt,
            core_pkg::op_bge, core_pkg::op_bltu, core_pkg::op_bgeu,
            core_pkg::op_ebreak, core_pkg::op_illegal: writes_rd = 1'b0;
            default: writes_rd = 1'b1;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            core_pkg::st_fetch: begin
                if (mem_done) state_next = core_pkg::st_exec;
            end
            core_pkg::st_exec: begin
                if (stops) state_next = core_pkg::st_halt;
                else if (needs_mem) state_next = core_pkg::st_mem;
                else state_next = core_pkg::st_wb;
            end
            core_pkg::st_mem: begin
                if (mem_done) state_next = core_pkg::st_wb;
            end
            core_pkg::st_wb: state_next = core_pkg::st_fetch;
            core_pkg::st_halt: state_next = core_pkg::st_halt;
            default: state_next = core_pkg::st_fetch;
        endcase
    end

    // request flags follow the next state, so they drop the cycle after mem_done.
    always_ff @(posedge clock) begin
        if (rst) begin
            state     <= core_pkg::st_fetch;
            fetch_req <= 1'b0;
            data_req  <= 1'b0;
        end else begin
            state     <= state_next;
            fetch_req <= (state_next == core_pkg::st_fetch);
            data_req  <= (state_next == core_pkg::st_mem);
        end
    end

    assign inst_load = (state == core_pkg::st_fetch) && mem_done;
    assign pc_step   = (state == core_pkg::st_wb);
    assign reg_wen   = pc_step && writes_rd;
    assign halted    = (state == core_pkg::st_halt);

endmodule

// File: source/core_decode.sv
module core_decode #(
    parameter int REG_ADDR_W = core_pkg::DEFAULT_REG_ADDR_W
) (
    input  logic [31:0]           inst,
    output core_pkg::op_t         op,
    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2,
    output logic [REG_ADDR_W-1:0] rd,
    output logic [31:0]           imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign rs1 = inst[15 +: REG_ADDR_W];
    assign rs2 = inst[20 +: REG_ADDR_W];
    assign rd  = inst[7 +: REG_ADDR_W];

    always_comb begin
        case (opcode)
            7'b0100011: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            7'b1100011: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            7'b0110111, 7'b0010111: imm = {inst[31:12], 12'b0};
            7'b1101111: imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = {{20{inst[31]}}, inst[31:20]};
        endcase
    end

    always_comb begin
        op = core_pkg::op_illegal;
        case (opcode)
            7'b0110011: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000: op = core_pkg::op_add;
                        3'b001: op = core_pkg::op_sll;
                        3'b010: op = core_pkg::op_slt;
                        3'b011: op = core_pkg::op_sltu;
                        3'b100: op = core_pkg::op_xor;
                        3'b101: op = core_pkg::op_srl;
                        3'b110: op = core_pkg::op_or;
                        default: op = core_pkg::op_and;
                    endcase
                end else if (funct7 == 7'b0100000) begin
                    if (funct3 == 3'b000) op = core_pkg::op_sub;
                    else if (funct3 == 3'b101) op = core_pkg::op_sra;
                end
            end
            7'b0010011: begin
                case (funct3)
                    3'b000: op = core_pkg::op_addi;
                    3'b010: op = core_pkg::op_slti;
                    3'b011: op = core_pkg::op_sltiu;
                    3'b100: op = core_pkg::op_xori;
                    3'b110: op = core_pkg::op_ori;
                    3'b111: op = core_pkg::op_andi;
                    3'b001: if (funct7 == 7'b0000000) op = core_pkg::op_slli;
                    default: begin
                        if (funct7 == 7'b0000000) op = core_pkg::op_srli;
                        else if (funct7 == 7'b0100000) op = core_pkg::op_srai;
                    end
                endcase
            end
            7'b1100011: begin
                case (funct3)
                    3'b000: op = core_pkg::op_beq;
                    3'b001: op = core_pkg::op_bne;
                    3'b100: op = core_pkg::op_blt;
                    3'b101: op = core_pkg::op_bge;
                    3'b110: op = core_pkg::op_bltu;
                    3'b111: op = core_pkg::op_bgeu;
                    default: op = core_pkg::op_illegal;
                endcase
            end
            7'b0000011: begin
                case (funct3)
                    3'b000: op = core_pkg::op_lb;
                    3'b001: op = core_pkg::op_lh;
                    3'b010: op = core_pkg::op_lw;
                    3'b100: op = core_pkg::op_lbu;
                    3'b101: op = core_pkg::op_lhu;
                    default: op = core_pkg::op_illegal;
                endcase
            end
            7'b0100011: begin
                case (funct3)
                    3'b000: op = core_pkg::op_sb;
                    3'b001: op = core_pkg::op_sh;
                    3'b010: op = core_pkg::op_sw;
                    default: op = core_pkg::op_illegal;
                endcase
            end
            7'b1101111: op = core_pkg::op_jal;
            7'b1100111: if (funct3 == 3'b000) op = core_pkg::op_jalr;
            7'b0110111: op = core_pkg::op_lui;
            7'b0010111: op = core_pkg::op_auipc;
            // only the exact ebreak encoding is accepted.
            7'b1110011: if (inst == 32'h0010_0073) op = core_pkg::op_ebreak;
            default: op = core_pkg::op_illegal;
        endcase
    end

endmodule

// File: source/core_mem_port.sv
module core_mem_port (
    input  logic          clock,
    input  logic          fetch_req,
    input  logic          data_req,
    input  core_pkg::op_t op,
    input  logic [31:0]   pc,
    input  logic [31:0]   data_addr,
    input  logic [31:0]   store_data,
    output logic          mem_req,
    output logic [31:0]   mem_addr,
    output logic          mem_wen,
    output logic [3:0]    mem_wstrb,
    output logic [31:0]   mem_wdata,
    input  logic          mem_ok,
    input  logic [31:0]   mem_rdata,
    output logic          mem_done,
    output logic [31:0]   load_data
);

    logic [31:0] bus_addr;
    logic [4:0]  lane_shift;
    logic [31:0] lane_q;

    // the data phase owns the port, otherwise the fetch does.
    assign bus_addr   = data_req ? data_addr : pc;
    assign lane_shift = {bus_addr[1:0], 3'b000};

    assign mem_req  = fetch_req || data_req;
    assign mem_addr = {bus_addr[31:2], 2'b00};
    assign mem_wen  = data_req && core_pkg::op_is_store(op);
    assign mem_done = mem_ok && mem_req;

    always_comb begin
        mem_wstrb = 4'b0000;
        mem_wdata = store_data;
        if (mem_wen) begin
            case (op)
                core_pkg::op_sb: begin
                    mem_wstrb = 4'b0001 << bus_addr[1:0];
                    mem_wdata = {24'b0, store_data[7:0]} << lane_shift;
                end
                core_pkg::op_sh: begin
                    mem_wstrb = 4'b0011 << {bus_addr[1], 1'b0};
                    mem_wdata = {16'b0, store_data[15:0]} << lane_shift;
                end
                default: mem_wstrb = 4'b1111;
            endcase
        end
    end

    // keep the addressed lane at the bottom for the writeback cycle.
    always_ff @(posedge clock) begin
        if (mem_done && data_req) begin
            lane_q <= mem_rdata >> lane_shift;
        end
    end

    always_comb begin
        case (op)
            core_pkg::op_lb:  load_data = {{24{lane_q[7]}}, lane_q[7:0]};
            core_pkg::op_lbu: load_data = {24'b0, lane_q[7:0]};
            core_pkg::op_lh:  load_data = {{16{lane_q[15]}}, lane_q[15:0]};
            core_pkg::op_lhu: load_data = {16'b0, lane_q[15:0]};
            default:          load_data = lane_q;
        endcase
    end

endmodule

// File: source/core_pc.sv
module core_pc #(
    parameter logic [31:0] RESET_PC = core_pkg::DEFAULT_RESET_PC
) (
    input  logic          clock,
    input  logic          rst,
    input  logic          step,
    input  core_pkg::op_t op,
    input  logic          take_branch,
    input  logic [31:0]   imm,
    input  logic [31:0]   rs1_data,
    output logic [31:0]   pc,
    output logic [31:0]   link
);

    logic [31:0] jalr_sum;
    logic [31:0] pc_next;

    assign link     = pc + 32'd4;
    assign jalr_sum = rs1_data + imm;

    // take_branch is only ever set for branch ops.
    always_comb begin
        if ((op == core_pkg::op_jal) || take_branch) begin
            pc_next = pc + imm;
        end else if (op == core_pkg::op_jalr) begin
            pc_next = {jalr_sum[31:1], 1'b0};
        end else begin
            pc_next = link;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (step) begin
            pc <= pc_next;
        end
    end

endmodule

// File: source/core_pkg.sv
package core_pkg;

    // one code per instruction; 39 codes need 6 bits.
    typedef enum logic [5:0] {
        op_add, op_sub, op_and, op_or, op_xor,
        op_slt, op_sltu, op_sll, op_srl, op_sra,
        op_addi, op_andi, op_ori, op_xori, op_slti,
        op_sltiu, op_slli, op_srli, op_srai,
        op_lb, op_lh, op_lw, op_lbu, op_lhu,
        op_sb, op_sh, op_sw,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_jal, op_jalr,
        op_lui, op_auipc,
        op_ebreak, op_illegal
    } op_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_exec,
        st_mem,
        st_wb,
        st_halt
    } state_t;

    localparam logic [31:0] DEFAULT_RESET_PC = 32'h0000_0000;
    localparam int DEFAULT_REG_ADDR_W = 4;

    function automatic logic op_is_load(op_t op);
        return op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
    endfunction

    function automatic logic op_is_store(op_t op);
        return op inside {op_sb, op_sh, op_sw};
    endfunction

endpackage

// File: source/core_regfile.sv
module core_regfile #(
    parameter int REG_ADDR_W = core_pkg::DEFAULT_REG_ADDR_W
) (
    input  logic                  clock,
    input  logic                  wen,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic [31:0]           wdata,
    input  logic [REG_ADDR_W-1:0] raddr1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    output logic [31:0]           rdata1,
    output logic [31:0]           rdata2
);

    logic [31:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clock) begin
        if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is never written, so force it on read.
    assign rdata1 = (raddr1 == '0) ? 32'b0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? 32'b0 : regs[raddr2];

endmodule

// File: source/core_top.sv
module core_top #(
    parameter logic [31:0] RESET_PC   = core_pkg::DEFAULT_RESET_PC,
    parameter int          REG_ADDR_W = core_pkg::DEFAULT_REG_ADDR_W
) (
    input  logic        clock,
    input  logic        rst,
    output logic        mem_req,
    output logic [31:0] mem_addr,
    output logic        mem_wen,
    output logic [3:0]  mem_wstrb,
    output logic [31:0] mem_wdata,
    input  logic        mem_ok,
    input  logic [31:0] mem_rdata,
    output logic [31:0] pc,
    output logic [31:0] inst,
    output logic        halted
);

    core_pkg::op_t         op;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [31:0]           imm;
    logic [31:0]           rs1_data;
    logic [31:0]           rs2_data;
    logic [31:0]           wb_data;
    logic [31:0]           alu_result;
    logic [31:0]           link;
    logic [31:0]           load_data;
    logic                  take_branch;
    logic                  fetch_req;
    logic                  data_req;
    logic                  inst_load;
    logic                  reg_wen;
    logic                  pc_step;
    logic                  mem_done;

    always_ff @(posedge clock) begin
        if (inst_load) begin
            inst <= mem_rdata;
        end
    end

    always_comb begin
        if (core_pkg::op_is_load(op)) begin
            wb_data = load_data;
        end else if ((op == core_pkg::op_jal) || (op == core_pkg::op_jalr)) begin
            wb_data = link;
        end else begin
            wb_data = alu_result;
        end
    end

    core_ctrl u_ctrl (
        .clock     (clock),
        .rst       (rst),
        .op        (op),
        .mem_done  (mem_done),
        .fetch_req (fetch_req),
        .data_req  (data_req),
        .inst_load (inst_load),
        .reg_wen   (reg_wen),
        .pc_step   (pc_step),
        .halted    (halted)
    );

    core_decode #(.REG_ADDR_W(REG_ADDR_W)) u_decode (
        .inst (inst),
        .op   (op),
        .rs1  (rs1),
        .rs2  (rs2),
        .rd   (rd),
        .imm  (imm)
    );

    core_regfile #(.REG_ADDR_W(REG_ADDR_W)) u_regfile (
        .clock  (clock),
        .wen    (reg_wen),
        .waddr  (rd),
        .wdata  (wb_data),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    core_alu u_alu (
        .op          (op),
        .a           (rs1_data),
        .b           (rs2_data),
        .imm         (imm),
        .pc          (pc),
        .result      (alu_result),
        .take_branch (take_branch)
    );

    core_pc #(.RESET_PC(RESET_PC)) u_pc (
        .clock       (clock),
        .rst         (rst),
        .step        (pc_step),
        .op          (op),
        .take_branch (take_branch),
        .imm         (imm),
        .rs1_data    (rs1_data),
        .pc          (pc),
        .link        (link)
    );

    core_mem_port u_mem_port (
        .clock      (clock),
        .fetch_req  (fetch_req),
        .data_req   (data_req),
        .op         (op),
        .pc         (pc),
        .data_addr  (alu_result),
        .store_data (rs2_data),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_wen    (mem_wen),
        .mem_wstrb  (mem_wstrb),
        .mem_wdata  (mem_wdata),
        .mem_ok     (mem_ok),
        .mem_rdata  (mem_rdata),
        .mem_done   (mem_done),
        .load_data  (load_data)
    );

endmodule

// File: testbench/tb_core.sv
module tb_core;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    logic        clock;
    logic        rst;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        mem_wen;
    logic [3:0]  mem_wstrb;
    logic [31:0] mem_wdata;
    logic        mem_ok;
    logic [31:0] mem_rdata;
    logic [31:0] pc;
    logic [31:0] inst;
    logic        halted;

    logic [31:0] mem [256];
    logic [31:0] exp_addr [$];
    logic [3:0]  exp_strb [$];
    logic [31:0] exp_data [$];
    int          prog_len;
    int          cycles;
    int          limit;

    core_top #(
        .RESET_PC   (RESET_PC),
        .REG_ADDR_W (core_pkg::DEFAULT_REG_ADDR_W)
    ) dut0 (
        .clock     (clock),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_wen   (mem_wen),
        .mem_wstrb (mem_wstrb),
        .mem_wdata (mem_wdata),
        .mem_ok    (mem_ok),
        .mem_rdata (mem_rdata),
        .pc        (pc),
        .inst      (inst),
        .halted    (halted)
    );

    function automatic logic [31:0] r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                           input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input int imm, input int rs1, input logic [2:0] f3,
                                           input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1,
                                           input logic [2:0] f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_type(input int imm, input int rs1, input int rs2,
                                           input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] u_type(input int imm, input int rd, input logic [6:0] opc);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] j_type(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6F};
    endfunction

    function automatic logic [31:0] lane_mask(input logic [3:0] strb);
        return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] want, input string what);
        if (got !== want) begin
            $display("Mismatch at time %0t: %s, got %h, expected %h", $time, what, got, want);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string why);
        $display("Error at time %0t: %s", $time, why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic count_cycle();
        cycles++;
        if (cycles > limit) begin
            abort_run($sformatf("the core did not halt within %0d cycles", limit));
        end
    endtask

    task automatic emit(input logic [31:0] word);
        logic [7:0] slot;
        slot = RESET_PC[9:2] + prog_len[7:0];
        mem[slot] = word;
        prog_len++;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [3:0] strb,
                                input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_strb.push_back(strb);
        exp_data.push_back(data);
    endtask

    // sw rs2 to the data area at x1 + offset.
    task automatic store_result(input int rs2, input int offset, input logic [31:0] value);
        emit(s_type(offset, rs2, 1, 3'b010));
        expect_store(32'h200 + offset, 4'hF, value);
    endtask

    // branch over a marker store of x3 (12), which only lands when not taken.
    task automatic branch_pair(input logic [2:0] f3, input int rs1, input int rs2,
                               input bit taken, input int offset);
        emit(b_type(8, rs1, rs2, f3));
        emit(s_type(offset, 3, 1, 3'b010));
        if (!taken) begin
            expect_store(32'h200 + offset, 4'hF, 32'd12);
        end
    endtask

    task automatic build_program();
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hA500_0000 | (i << 2);
        end
        prog_len = 0;
        emit(i_type(32'h200, 0, 3'b000, 1, 7'h13));
        emit(i_type(-7, 0, 3'b000, 2, 7'h13));
        emit(i_type(12, 0, 3'b000, 3, 7'h13));
        emit(u_type(32'h12345, 4, 7'h37));
        emit(i_type(32'h678, 4, 3'b000, 4, 7'h13));
        // x2 = 0xfffffff9, x3 = 12, x4 = 0x12345678.
        emit(r_type(7'h00, 3, 2, 3'b000, 5));
        store_result(5, 0, 32'h0000_0005);
        emit(r_type(7'h20, 3, 2, 3'b000, 5));
        store_result(5, 4, 32'hFFFF_FFED);
        emit(r_type(7'h00, 3, 4, 3'b111, 5));
        store_result(5, 8, 32'h0000_0008);
        emit(r_type(7'h00, 4, 3, 3'b110, 5));
        store_result(5, 12, 32'h1234_567C);
        emit(r_type(7'h00, 2, 4, 3'b100, 5));
        store_result(5, 16, 32'hEDCB_A981);
        emit(r_type(7'h00, 3, 2, 3'b010, 5));
        store_result(5, 20, 32'h0000_0001);
        emit(r_type(7'h00, 3, 2, 3'b011, 5));
        store_result(5, 24, 32'h0000_0000);
        emit(r_type(7'h00, 3, 4, 3'b001, 5));
        store_result(5, 28, 32'h4567_8000);
        emit(r_type(7'h00, 3, 2, 3'b101, 5));
        store_result(5, 32, 32'h000F_FFFF);
        emit(r_type(7'h20, 3, 2, 3'b101, 5));
        store_result(5, 36, 32'hFFFF_FFFF);
        emit(i_type(-1, 4, 3'b100, 5, 7'h13));
        store_result(5, 40, 32'hEDCB_A987);
        emit(i_type(-1, 3, 3'b011, 5, 7'h13));
        store_result(5, 44, 32'h0000_0001);
        emit(i_type(32'h401, 2, 3'b101, 5, 7'h13));
        store_result(5, 48, 32'hFFFF_FFFC);
        // auipc sits at 0x7c.
        emit(u_type(1, 5, 7'h17));
        store_result(5, 52, RESET_PC + 32'h107C);
        // bytes and halves build 0x78f978f9 at 0x240 and 0xfff95678 at 0x244.
        emit(s_type(64, 2, 1, 3'b000));
        expect_store(32'h240, 4'b0001, 32'h0000_00F9);
        emit(s_type(65, 4, 1, 3'b000));
        expect_store(32'h240, 4'b0010, 32'h0000_7800);
        emit(s_type(66, 2, 1, 3'b000));
        expect_store(32'h240, 4'b0100, 32'h00F9_0000);
        emit(s_type(67, 4, 1, 3'b000));
        expect_store(32'h240, 4'b1000, 32'h7800_0000);
        emit(s_type(68, 4, 1, 3'b001));
        expect_store(32'h244, 4'b0011, 32'h0000_5678);
        emit(s_type(70, 2, 1, 3'b001));
        expect_store(32'h244, 4'b1100, 32'hFFF9_0000);
        emit(i_type(64, 1, 3'b010, 6, 7'h03));
        store_result(6, 56, 32'h78F9_78F9);
        emit(i_type(68, 1, 3'b010, 6, 7'h03));
        store_result(6, 60, 32'hFFF9_5678);
        emit(i_type(64, 1, 3'b000, 7, 7'h03));
        store_result(7, 72, 32'hFFFF_FFF9);
        emit(i_type(66, 1, 3'b100, 7, 7'h03));
        store_result(7, 76, 32'h0000_00F9);
        emit(i_type(70, 1, 3'b001, 7, 7'h03));
        store_result(7, 80, 32'hFFFF_FFF9);
        emit(i_type(70, 1, 3'b101, 7, 7'h03));
        store_result(7, 84, 32'h0000_FFF9);
        // each branch kind once taken and once not.
        branch_pair(3'b000, 3, 3, 1'b1, 96);
        branch_pair(3'b000, 2, 3, 1'b0, 100);
        branch_pair(3'b001, 2, 3, 1'b1, 104);
        branch_pair(3'b100, 2, 3, 1'b1, 108);
        branch_pair(3'b101, 2, 3, 1'b0, 112);
        branch_pair(3'b110, 2, 3, 1'b0, 116);
        branch_pair(3'b111, 2, 3, 1'b1, 120);
        branch_pair(3'b001, 3, 3, 1'b0, 124);
        branch_pair(3'b101, 3, 2, 1'b1, 128);
        branch_pair(3'b100, 3, 2, 1'b0, 132);
        branch_pair(3'b110, 3, 2, 1'b1, 136);
        branch_pair(3'b111, 3, 2, 1'b0, 140);
        // jal at 0x12c skips one store, link is 0x130.
        emit(j_type(8, 10));
        emit(s_type(144, 3, 1, 3'b010));
        store_result(10, 148, RESET_PC + 32'h130);
        // jalr at 0x13c to 0x145 lands on 0x144, link is 0x140.
        emit(i_type(32'h145, 0, 3'b000, 11, 7'h13));
        emit(i_type(0, 11, 3'b000, 12, 7'h67));
        emit(s_type(152, 3, 1, 3'b010));
        store_result(12, 156, RESET_PC + 32'h140);
        emit(32'h0010_0073);
    endtask

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // answers each request after 0 to 3 wait cycles and checks the bus holds meanwhile.
    initial begin : memory_model
        logic        busy;
        int          wait_cycles;
        logic [7:0]  index;
        logic [31:0] held_addr;
        logic [31:0] held_wdata;
        logic [3:0]  held_wstrb;
        logic        held_wen;
        void'($urandom(91));
        busy = 1'b0;
        wait_cycles = 0;
        forever begin
            @(posedge clock);
            #1;
            mem_ok = 1'b0;
            if (!rst && mem_req && !busy) begin
                busy = 1'b1;
                wait_cycles = $urandom_range(3, 0);
                held_addr = mem_addr;
                held_wen = mem_wen;
                held_wstrb = mem_wstrb;
                held_wdata = mem_wdata;
            end
            if (busy) begin
                if (!mem_req) begin
                    abort_run("mem_req dropped before mem_ok");
                end
                check(mem_addr, held_addr, "mem_addr while waiting");
                check({31'b0, mem_wen}, {31'b0, held_wen}, "mem_wen while waiting");
                check({28'b0, mem_wstrb}, {28'b0, held_wstrb}, "mem_wstrb while waiting");
                check(mem_wdata, held_wdata, "mem_wdata while waiting");
                if (wait_cycles == 0) begin
                    index = mem_addr[9:2];
                    if (mem_wen) begin
                        for (int lane = 0; lane < 4; lane++) begin
                            if (mem_wstrb[lane]) begin
                                mem[index][8*lane +: 8] = mem_wdata[8*lane +: 8];
                            end
                        end
                    end else begin
                        mem_rdata = mem[index];
                    end
                    mem_ok = 1'b1;
                    busy = 1'b0;
                end else begin
                    wait_cycles--;
                end
            end
        end
    end

    initial begin : main
        rst = 1'b1;
        mem_ok = 1'b0;
        mem_rdata = 32'b0;
        cycles = 0;
        build_program();
        limit = prog_len * (3 + 3 + 2) * 2;
        repeat (4) @(posedge clock);
        #1;
        rst = 1'b0;
        @(negedge clock);
        check({31'b0, halted}, 32'd0, "halted after reset");
        while (!mem_req) begin
            @(negedge clock);
            count_cycle();
        end
        check(mem_addr, RESET_PC, "first fetch address");
        for (int idx = 0; idx < exp_addr.size(); idx++) begin
            while (!(mem_req && mem_wen && mem_ok)) begin
                if (halted) begin
                    abort_run($sformatf("core halted with store %0d still expected", idx));
                end
                @(negedge clock);
                count_cycle();
            end
            check(mem_addr, exp_addr[idx], $sformatf("store %0d address", idx));
            check({28'b0, mem_wstrb}, {28'b0, exp_strb[idx]}, $sformatf("store %0d strobe", idx));
            check(mem_wdata & lane_mask(mem_wstrb), exp_data[idx],
                  $sformatf("store %0d data", idx));
            @(negedge clock);
            count_cycle();
        end
        while (!halted) begin
            if (mem_req && mem_wen && mem_ok) begin
                abort_run($sformatf("unexpected store to address %h", mem_addr));
            end
            @(negedge clock);
            count_cycle();
        end
        // ebreak is the last word of the program.
        check(pc, RESET_PC + 4 * (prog_len - 1), "pc at halt");
        check(inst, 32'h0010_0073, "inst at halt");
        repeat (20) begin
            @(negedge clock);
            check({31'b0, mem_req}, 32'd0, "mem_req after halt");
        end
        $display("TB PASSED");
        $finish;
    end

endmodule
